//--- bus_pkg.sv
package bus_pkg;

   //////////////////////////////
   // CPU bus
   //////////////////////////////

   // One sampled level of the Z80-style bus
   // Strobes are active low as on the real CPU
   typedef struct packed {
      logic [15:0] addr;
      // CPU write data
      logic [7:0]  dout;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
   } cpu_bus_t;

   //////////////////////////////
   // I/O ports
   //////////////////////////////

   // Register address and data ports, full 16-bit decode
   localparam logic [15:0] PORT_REG_ADDR = 16'hFC3B;
   localparam logic [15:0] PORT_REG_DATA = 16'hFD3B;

   // Kempston-style joystick, low address byte only
   localparam logic [7:0]  PORT_JOY      = 8'h1F;

   // Register numbers behind the data port
   localparam logic [7:0]  REG_SPI_CTRL  = 8'h02;
   localparam logic [7:0]  REG_SPI_DATA  = 8'h03;

   // Value of a read that nobody claims
   localparam logic [7:0]  BUS_FLOAT     = 8'hFF;

endpackage

//--- spi_pkg.sv
package spi_pkg;

   // clk cycles per sclk half-period
   localparam int SPI_HALF   = 2;
   // Bits in one transfer
   localparam int SPI_BITS   = 8;

   // Counter widths derived from the above
   localparam int SPI_HALF_W = (SPI_HALF > 1) ? $clog2(SPI_HALF) : 1;
   localparam int SPI_BIT_W  = $clog2(SPI_BITS);

   // Transfer FSM states
   // LOW and HIGH are the two halves of one bit
   typedef enum logic [1:0] {
      SPI_IDLE = 2'd0,
      SPI_LOW  = 2'd1,
      SPI_HIGH = 2'd2,
      SPI_DONE = 2'd3
   } spi_state_e;

   // Flash pins as seen on the board
   typedef struct packed {
      logic cs_n;
      logic sclk;
      logic mosi;
   } spi_pins_t;

endpackage

//--- reg_port.sv
module reg_port import bus_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  cpu_bus_t   bus,
   output logic [7:0] reg_addr,
   output logic [7:0] wr_data,
   output logic       reg_wr,
   output logic       reg_rd,
   output logic       addr_rd_en
);

   logic io_wr;
   logic io_rd;
   logic io_wr_q;
   logic wr_first;
   logic hit_addr;
   logic hit_data;

   // Raw I/O access levels
   assign io_wr    = !bus.iorq_n && !bus.wr_n;
   assign io_rd    = !bus.iorq_n && !bus.rd_n;

   // Full decode of both ports
   assign hit_addr = (bus.addr == PORT_REG_ADDR);
   assign hit_data = (bus.addr == PORT_REG_DATA);

   // First cycle of a write, CPU holds the access for several clocks
   assign wr_first = io_wr && !io_wr_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         io_wr_q  <= 1'b0;
         reg_addr <= 8'h00;
      end else begin
         io_wr_q <= io_wr;
         // Latch the register number once per write
         if (wr_first && hit_addr) begin
            reg_addr <= bus.dout;
         end
      end
   end

   // One-cycle strobe towards the register owners
   assign reg_wr     = wr_first && hit_data;
   // Level for the whole read
   assign reg_rd     = io_rd && hit_data;
   assign addr_rd_en = io_rd && hit_addr;
   assign wr_data    = bus.dout;

endmodule

//--- spi_bit_timer.sv
module spi_bit_timer import spi_pkg::*; (
   input  logic clk,
   input  logic arst_n,
   input  logic run,
   output logic half_tick,
   output logic last_bit
);

   logic [SPI_HALF_W-1:0] pre_cnt;
   logic [SPI_BIT_W-1:0]  bit_cnt;
   // 0 in the low half, 1 in the high half
   logic                  phase;

   // End of every half-period
   assign half_tick = run && (pre_cnt == SPI_HALF_W'(SPI_HALF - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pre_cnt <= '0;
         bit_cnt <= '0;
         phase   <= 1'b0;
      end else if (!run) begin
         // Idle between transfers, start each one from zero
         pre_cnt <= '0;
         bit_cnt <= '0;
         phase   <= 1'b0;
      end else if (half_tick) begin
         pre_cnt <= '0;
         phase   <= !phase;
         // Bit ends with its high half
         if (phase) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         pre_cnt <= pre_cnt + 1'b1;
      end
   end

   assign last_bit = (bit_cnt == SPI_BIT_W'(SPI_BITS - 1));

endmodule

//--- spi_fsm.sv
module spi_fsm import bus_pkg::*, spi_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [7:0] reg_addr,
   input  logic       reg_wr,
   input  logic       half_tick,
   input  logic       last_bit,
   output logic       run,
   output logic       load,
   output logic       shift,
   output logic       sample,
   output logic       sclk,
   output logic       busy
);

   spi_state_e state;
   spi_state_e state_nxt;
   logic       start;

   // Data register write while idle starts a byte
   // Writes during a transfer fall through here
   assign start = reg_wr && (reg_addr == REG_SPI_DATA) && (state == SPI_IDLE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= SPI_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      unique case (state)
         SPI_IDLE: if (start) state_nxt = SPI_LOW;
         SPI_LOW:  if (half_tick) state_nxt = SPI_HIGH;
         SPI_HIGH: begin
            if (half_tick) begin
               state_nxt = last_bit ? SPI_DONE : SPI_LOW;
            end
         end
         // One cycle to settle before the next start
         SPI_DONE: state_nxt = SPI_IDLE;
         default:  state_nxt = SPI_IDLE;
      endcase
   end

   ///////////////////////////////
   // Shifter and timer controls
   ///////////////////////////////

   assign run    = (state == SPI_LOW) || (state == SPI_HIGH);
   assign load   = start;
   // Sample miso at the end of each high half
   assign sample = (state == SPI_HIGH) && half_tick;
   // Next mosi bit as the following low half begins
   assign shift  = sample && !last_bit;

   // Mode 0, clock high only in the second half
   assign sclk   = (state == SPI_HIGH);
   assign busy   = run;

endmodule

//--- spi_shifter.sv
module spi_shifter import bus_pkg::*, spi_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [7:0] reg_addr,
   input  logic       reg_wr,
   input  logic [7:0] wr_data,
   input  logic       load,
   input  logic       shift,
   input  logic       sample,
   input  logic       sclk,
   input  logic       miso,
   input  logic       busy,
   output spi_pins_t  pins,
   output logic [7:0] rx_data,
   output logic [7:0] ctrl_rd
);

   logic [7:0] tx_shift;
   logic [7:0] rx_shift;
   logic       cs_n;
   logic       busy_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_shift <= 8'h00;
         rx_shift <= 8'h00;
         rx_data  <= 8'h00;
         cs_n     <= 1'b1;
         busy_q   <= 1'b0;
      end else begin
         busy_q <= busy;
         // MSB first out
         if (load) begin
            tx_shift <= wr_data;
         end else if (shift) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
         // MSB first in, one bit per high half
         if (sample) begin
            rx_shift <= {rx_shift[6:0], miso};
         end
         // Chip select is bit 0 of the control register
         if (reg_wr && (reg_addr == REG_SPI_CTRL)) begin
            cs_n <= wr_data[0];
         end
         // Byte complete when busy drops
         if (busy_q && !busy) begin
            rx_data <= rx_shift;
         end
      end
   end

   assign pins    = '{cs_n: cs_n, sclk: sclk, mosi: tx_shift[7]};
   // Status: busy on top, chip select at the bottom
   assign ctrl_rd = {busy, 6'b000000, cs_n};

endmodule

//--- io_decode.sv
module io_decode import bus_pkg::*; (
   input  cpu_bus_t   bus,
   input  logic [4:0] joy,
   input  logic [7:0] reg_addr,
   input  logic       reg_rd,
   input  logic       addr_rd_en,
   input  logic [7:0] ctrl_rd,
   input  logic [7:0] rx_data,
   output logic [7:0] cpu_din
);

   logic [7:0] reg_val;
   logic       joy_rd;

   ///////////////////////////////
   // Register file read
   ///////////////////////////////

   always_comb begin
      unique case (reg_addr)
         REG_SPI_CTRL: reg_val = ctrl_rd;
         REG_SPI_DATA: reg_val = rx_data;
         // Unused registers float high
         default:      reg_val = BUS_FLOAT;
      endcase
   end

   // Joystick answers on the low address byte alone
   assign joy_rd = !bus.iorq_n && !bus.rd_n && (bus.addr[7:0] == PORT_JOY);

   ///////////////////////////////
   // CPU read mux
   ///////////////////////////////

   always_comb begin
      // Highest priority first
      if (addr_rd_en) begin
         cpu_din = reg_addr;
      end else if (reg_rd) begin
         cpu_din = reg_val;
      end else if (joy_rd) begin
         // Top three lines read zero
         cpu_din = {3'b000, joy};
      end else begin
         cpu_din = BUS_FLOAT;
      end
   end

endmodule

//--- io_subsystem.sv
module io_subsystem import bus_pkg::*, spi_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  cpu_bus_t   bus,
   input  logic [4:0] joy,
   input  logic       miso,
   output logic [7:0] cpu_din,
   output spi_pins_t  spi
);

   // Register port
   logic [7:0] reg_addr;
   logic [7:0] wr_data;
   logic       reg_wr;
   logic       reg_rd;
   logic       addr_rd_en;

   // SPI control
   logic       half_tick;
   logic       last_bit;
   logic       run;
   logic       load;
   logic       shift;
   logic       sample;
   logic       sclk;
   logic       busy;

   // Read-back values
   logic [7:0] rx_data;
   logic [7:0] ctrl_rd;

   reg_port u_reg_port (.clk, .arst_n, .bus, .reg_addr, .wr_data, .reg_wr, .reg_rd, .addr_rd_en);

   spi_bit_timer u_spi_bit_timer (.clk, .arst_n, .run, .half_tick, .last_bit);

   spi_fsm u_spi_fsm (
      .clk, .arst_n, .reg_addr, .reg_wr, .half_tick, .last_bit,
      .run, .load, .shift, .sample, .sclk, .busy
   );

   spi_shifter u_spi_shifter (
      .clk, .arst_n, .reg_addr, .reg_wr, .wr_data, .load, .shift, .sample,
      .sclk, .miso, .busy, .pins(spi), .rx_data, .ctrl_rd
   );

   io_decode u_io_decode (.bus, .joy, .reg_addr, .reg_rd, .addr_rd_en, .ctrl_rd, .rx_data, .cpu_din);

endmodule

//--- tb_io_subsystem_assert.sv
module tb_io_subsystem_assert import spi_pkg::*; (
   input logic       clk,
   input logic       arst_n,
   input logic       sclk,
   input logic       busy,
   input logic       reg_wr
);
   timeunit 1ns;
   timeprecision 1ps;

   // Two halves per bit, one bit per data bit
   localparam int unsigned BUSY_CYCLES = 2 * SPI_HALF * SPI_BITS;

   int unsigned busy_len;
   int unsigned high_len;
   int unsigned sclk_err;
   int unsigned busy_err;
   int unsigned strobe_err;
   // Read by the testbench at the end
   int unsigned fail_cnt;

   assign fail_cnt = sclk_err + busy_err + strobe_err;

   // Length of the current busy run and sclk high half
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_len <= 0;
         high_len <= 0;
      end else begin
         if (busy) begin
            busy_len <= busy_len + 1;
         end else begin
            busy_len <= 0;
         end
         if (sclk) begin
            high_len <= high_len + 1;
         end else begin
            high_len <= 0;
         end
      end
   end

   //////////////////////////////
   // SPI FSM properties
   //////////////////////////////

   // Each sclk high half is one timer half-period
   sclk_high_width: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(sclk) |-> (high_len == SPI_HALF))
   else begin
      sclk_err++;
      $error("sclk high for %0d cycles instead of %0d", high_len, SPI_HALF);
   end

   busy_length: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(busy) |-> (busy_len == BUSY_CYCLES))
   else begin
      busy_err++;
      $error("busy lasted %0d cycles instead of %0d", busy_len, BUSY_CYCLES);
   end

   // Write strobe is a single clock wide
   strobe_width: assert property (@(posedge clk) disable iff (!arst_n)
      reg_wr |=> !reg_wr)
   else begin
      strobe_err++;
      $error("reg_wr held high for more than one cycle");
   end

endmodule

//--- tb_io_subsystem.sv
module tb_io_subsystem import bus_pkg::*, spi_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   // Whole sequence runs well under half of this
   localparam int unsigned TIMEOUT_CYCLES = 2000;
   // Transfer start to idle status seen
   localparam int unsigned POLL_LIMIT     = 40;
   localparam int          N_BYTES        = 4;
   localparam cpu_bus_t    BUS_IDLE       =
      '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};

   logic        clk = 1'b0;
   logic        arst_n;
   cpu_bus_t    bus;
   logic [4:0]  joy;
   logic        miso;
   logic [7:0]  cpu_din;
   spi_pins_t   spi_pins;

   int unsigned cyc = 0;
   logic [31:0] lfsr = 32'd32973;

   // SPI slave model state
   logic [7:0]  slave_byte = 8'h00;
   logic [7:0]  slave_out;
   logic [7:0]  mosi_cap = 8'h00;
   int unsigned sclk_rises = 0;
   int unsigned sclk_falls = 0;
   int unsigned rise_base = 0;
   int unsigned fall_base = 0;
   logic        sclk_w;
   logic        mosi_w;

   io_subsystem uut (.clk, .arst_n, .bus, .joy, .miso, .cpu_din, .spi(spi_pins));

   bind spi_fsm tb_io_subsystem_assert u_fsm_assert (
      .clk(clk), .arst_n(arst_n), .sclk(sclk), .busy(busy), .reg_wr(reg_wr)
   );

   always #4 clk = ~clk;

   //////////////////////////////
   // SPI slave model
   //////////////////////////////

   assign sclk_w    = spi_pins.sclk;
   assign mosi_w    = spi_pins.mosi;
   // MSB first, next bit after each falling edge of this transfer
   assign slave_out = slave_byte << (sclk_falls - fall_base);
   assign miso      = slave_out[7];

   always @(posedge sclk_w) begin
      mosi_cap   <= {mosi_cap[6:0], mosi_w};
      sclk_rises <= sclk_rises + 1;
   end

   always @(negedge sclk_w) begin
      sclk_falls <= sclk_falls + 1;
   end

   // Cycle count and run limit
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not complete within %0d clock cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $fatal(1, "simulation timeout");
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1, "check failed");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] t=%0t %s got=0x%02h expected=0x%02h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("[FAIL] t=%0t %s got=%b expected=%b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input int unsigned got,
                              input int unsigned exp);
      assert (got == exp) else begin
         $display("[FAIL] t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [7:0] val);
      val = 8'h00;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[6:0], lfsr[0]};
      end
   endtask

   //////////////////////////////
   // Bus tasks
   //////////////////////////////

   // Called right after a rising edge, returns right after one
   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      bus <= '{addr: port, dout: data, iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0};
      repeat (4) @(posedge clk);
      bus <= BUS_IDLE;
      @(posedge clk);
   endtask

   task automatic io_read(input logic [15:0] port, output logic [7:0] data);
      bus <= '{addr: port, dout: 8'h00, iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1};
      repeat (3) @(posedge clk);
      // Middle of the last access cycle
      @(negedge clk);
      data = cpu_din;
      @(posedge clk);
      bus <= BUS_IDLE;
      @(posedge clk);
   endtask

   task automatic reg_write(input logic [7:0] num, input logic [7:0] data);
      io_write(PORT_REG_ADDR, num);
      io_write(PORT_REG_DATA, data);
   endtask

   task automatic reg_read(input logic [7:0] num, output logic [7:0] data);
      io_write(PORT_REG_ADDR, num);
      io_read(PORT_REG_DATA, data);
   endtask

   task automatic sample_pins(output spi_pins_t p);
      @(negedge clk);
      p = spi_pins;
      @(posedge clk);
   endtask

   // Arm the slave model, then start one byte
   task automatic start_transfer(input logic [7:0] master, input logic [7:0] slave,
                                 output int unsigned t0);
      slave_byte = slave;
      fall_base  = sclk_falls;
      rise_base  = sclk_rises;
      io_write(PORT_REG_ADDR, REG_SPI_DATA);
      t0 = cyc;
      io_write(PORT_REG_DATA, master);
   endtask

   // Poll the status register until busy clears
   task automatic wait_spi_idle(input int unsigned t0);
      logic [7:0] st;
      logic       idle;
      idle = 1'b0;
      io_write(PORT_REG_ADDR, REG_SPI_CTRL);
      // Byte still shifting at the first poll
      io_read(PORT_REG_DATA, st);
      check_bit("cpu_din spi status busy", st[7], 1'b1);
      while (!idle && (cyc - t0) < POLL_LIMIT) begin
         io_read(PORT_REG_DATA, st);
         idle = !st[7];
      end
      assert (idle && (cyc - t0) <= POLL_LIMIT) else begin
         $display("SPI status still busy %0d cycles after the transfer start", cyc - t0);
         stop_run();
      end
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic test_reset_state();
      spi_pins_t  p;
      logic [7:0] rd;
      sample_pins(p);
      check_bit("spi.cs_n", p.cs_n, 1'b1);
      check_bit("spi.sclk", p.sclk, 1'b0);
      io_read(PORT_REG_ADDR, rd);
      check_byte("cpu_din reg_addr", rd, 8'h00);
      // busy clear, cs_n high
      reg_read(REG_SPI_CTRL, rd);
      check_byte("cpu_din spi status", rd, 8'h01);
   endtask

   task automatic test_addr_readback();
      logic [7:0] v;
      logic [7:0] rd;
      for (int i = 0; i < N_BYTES; i++) begin
         rand_bits(8, v);
         io_write(PORT_REG_ADDR, v);
         io_read(PORT_REG_ADDR, rd);
         check_byte("cpu_din reg_addr", rd, v);
      end
      // Nothing lives at register 0x40
      reg_read(8'h40, rd);
      check_byte("cpu_din unused register", rd, 8'hFF);
   endtask

   task automatic test_joystick();
      logic [7:0] v;
      logic [7:0] hi;
      logic [7:0] rd;
      for (int i = 0; i < N_BYTES; i++) begin
         rand_bits(5, v);
         rand_bits(8, hi);
         joy <= v[4:0];
         io_read({hi, PORT_JOY}, rd);
         check_byte("cpu_din joystick", rd, {3'b000, v[4:0]});
      end
      io_read(16'h12FE, rd);
      check_byte("cpu_din unused port", rd, 8'hFF);
   endtask

   task automatic test_chip_select();
      spi_pins_t  p;
      logic [7:0] rd;
      reg_write(REG_SPI_CTRL, 8'h00);
      sample_pins(p);
      check_bit("spi.cs_n", p.cs_n, 1'b0);
      io_read(PORT_REG_DATA, rd);
      check_byte("cpu_din spi status", rd, 8'h00);
      reg_write(REG_SPI_CTRL, 8'h01);
      sample_pins(p);
      check_bit("spi.cs_n", p.cs_n, 1'b1);
      io_read(PORT_REG_DATA, rd);
      check_byte("cpu_din spi status", rd, 8'h01);
   endtask

   task automatic test_transfers();
      logic [7:0]  m;
      logic [7:0]  s;
      logic [7:0]  rd;
      int unsigned t0;
      for (int i = 0; i < N_BYTES; i++) begin
         rand_bits(8, m);
         rand_bits(8, s);
         start_transfer(m, s, t0);
         wait_spi_idle(t0);
         check_byte("mosi byte", mosi_cap, m);
         reg_read(REG_SPI_DATA, rd);
         check_byte("cpu_din spi rx_data", rd, s);
      end
   endtask

   // Second data write lands while the first byte is still shifting
   task automatic test_busy_write();
      logic [7:0]  m;
      logic [7:0]  s;
      int unsigned t0;
      rand_bits(8, m);
      rand_bits(8, s);
      start_transfer(m, s, t0);
      io_write(PORT_REG_DATA, ~m);
      wait_spi_idle(t0);
      check_byte("mosi byte", mosi_cap, m);
      check_count("sclk rising edges", sclk_rises - rise_base, 8);
   endtask

   initial begin
      arst_n <= 1'b0;
      bus    <= BUS_IDLE;
      joy    <= 5'h00;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      test_reset_state();
      test_addr_readback();
      test_joystick();
      test_chip_select();
      test_transfers();
      test_busy_write();
      repeat (4) @(posedge clk);
      if (uut.u_spi_fsm.u_fsm_assert.fail_cnt == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("SPI FSM assertions failed %0d times",
                  uut.u_spi_fsm.u_fsm_assert.fail_cnt);
         $display("=== FAIL ===");
         $fatal(1, "assertion failures");
      end
   end

endmodule

//--- vlog.f
bus_pkg.sv
spi_pkg.sv
reg_port.sv
spi_bit_timer.sv
spi_fsm.sv
spi_shifter.sv
io_decode.sv
io_subsystem.sv
tb_io_subsystem_assert.sv
tb_io_subsystem.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_io_subsystem \
   -f vlog.f -Mdir obj_dir -o sim_io_subsystem || exit 1
(./obj_dir/sim_io_subsystem > sim.log 2>&1 || true) \
   && grep -q "^=== PASS ===$" sim.log \
   && echo "Simulation result found in sim.log: passed" \
   || { echo "Simulation did not pass, see sim.log"; exit 1; }
